//--- cpu_pkg.sv
package cpu_pkg;

  localparam int X_SIZE = 16;     // Activation word width
  localparam int W_SIZE = 16;     // Weight word width
  localparam int TRIT_SIZE = 4;   // Rotation amount width
  localparam int INSTR_SIZE = 16; // Instruction word width

  // Opcodes sit in the low five bits of an instruction
  typedef enum logic [4:0] {
    set_i_0,          // I = 0
    set_trit_next,    // TRIT = next word
    set_h_next,       // H = next word
    d_inc,
    d_dec,
    a_inc,
    a_dec,
    x_from_d0,        // X = *D.x
    y_from_d1,        // Y = *D.y
    xy_from_d,
    inference_from_y,
    w_from_a,         // W = *A
    a_from_w,         // *A = W
    x_from_h,         // X = *H
    h_from_x,         // *H = X
    swap_xy,
    x_from_y,
    y_from_x,
    x_xor,
    y_xor,
    x_and,
    y_and,
    x_or,
    y_or,
    interweave,
    backprop,
    stoch_grad
  } op_e;

  // One data memory entry
  typedef struct packed {
    logic [X_SIZE-1:0] x;
    logic [X_SIZE-1:0] y;
  } xy_pair_t;

  // Load port target
  typedef enum logic [1:0] {
    sel_program,
    sel_data,
    sel_weight,
    sel_heap
  } load_sel_e;

endpackage

//--- interweave.sv
`timescale 1ns/1ps

module interweave (
  input  logic [cpu_pkg::X_SIZE-1:0]    x,
  input  logic [cpu_pkg::W_SIZE-1:0]    w,
  input  logic [cpu_pkg::TRIT_SIZE-1:0] trit,
  output logic [cpu_pkg::X_SIZE-1:0]    y
);

  // Rotate x down by trit, then mix in the weight bit by bit
  always_comb begin
    for (int i = 0; i < cpu_pkg::X_SIZE; i++) begin
      y[i] = x[(i + int'(trit)) % cpu_pkg::X_SIZE] ^ w[i];
    end
  end

endmodule

//--- binterweave.sv
`timescale 1ns/1ps

module binterweave (
  input  logic [cpu_pkg::X_SIZE-1:0]    y,
  input  logic [cpu_pkg::W_SIZE-1:0]    w,
  input  logic [cpu_pkg::TRIT_SIZE-1:0] trit,
  output logic [cpu_pkg::X_SIZE-1:0]    x,
  output logic [cpu_pkg::W_SIZE-1:0]    grad
);

  // Undo the weight mix at the source index, then rotate back up
  always_comb begin
    int idx;
    for (int j = 0; j < cpu_pkg::X_SIZE; j++) begin
      idx = (j - int'(trit) + cpu_pkg::X_SIZE) % cpu_pkg::X_SIZE;
      x[j] = y[idx] ^ w[idx];
    end
  end

  assign grad = y ^ w; // Bits where output and weight disagree

endmodule

//--- stoch_grad.sv
`timescale 1ns/1ps

module stoch_grad #(
  parameter logic [cpu_pkg::W_SIZE-1:0] SEED = 16'hb26
) (
  input  logic                      clk_in,
  input  logic                      rst_in,
  input  logic                      step,
  input  logic [cpu_pkg::W_SIZE-1:0] grad,
  output logic [cpu_pkg::W_SIZE-1:0] flip
);

  localparam logic [cpu_pkg::W_SIZE-1:0] TAPS = 16'hb400;

  logic [cpu_pkg::W_SIZE-1:0] lfsr;

  // Galois LFSR, shifts right and folds the taps in when bit 0 falls out
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      lfsr <= SEED;
    end else if (step) begin
      lfsr <= (lfsr >> 1) ^ (lfsr[0] ? TAPS : '0);
    end
  end

  assign flip = grad & lfsr; // Mask uses the state before this step

endmodule

//--- medium_mem.sv
`timescale 1ns/1ps

module medium_mem #(
  parameter type word_t = logic [15:0],
  parameter int  DEPTH = 16,
  parameter int  LATENCY = 2
) (
  input  logic                     clk_in,
  input  logic                     rst_in,
  input  logic [$clog2(DEPTH)-1:0] addr,
  input  logic                     read_en,
  input  logic                     write_en,
  input  word_t                    wdata,
  output word_t                    rdata,
  output logic                     finished,
  input  logic                     load_en,
  input  logic [$clog2(DEPTH)-1:0] load_addr,
  input  word_t                    load_data
);

  word_t mem [DEPTH];
  word_t rdata_q;                // Read word, held until finished
  logic [LATENCY-1:0] pending;   // One bit per cycle of latency

  always_ff @(posedge clk_in) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end else if (write_en) begin
      mem[addr] <= wdata;        // Write commits on the request cycle
    end
    if (read_en) begin
      rdata_q <= mem[addr];
    end
  end

  // Request travels down the shift register to pace the finished pulse
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pending <= '0;
    end else begin
      pending <= (pending << 1) | LATENCY'(read_en | write_en);
    end
  end

  assign finished = pending[LATENCY-1];
  assign rdata = rdata_q;

endmodule

//--- program_rom.sv
`timescale 1ns/1ps

module program_rom #(
  parameter int DEPTH = 64
) (
  input  logic                          clk_in,
  input  logic                          rst_in,
  input  logic [$clog2(DEPTH)-1:0]      addr,
  input  logic                          ready,
  output logic [cpu_pkg::INSTR_SIZE-1:0] instruction,
  output logic                          valid,
  input  logic                          load_en,
  input  logic [$clog2(DEPTH)-1:0]      load_addr,
  input  logic [cpu_pkg::INSTR_SIZE-1:0] load_data
);

  logic [cpu_pkg::INSTR_SIZE-1:0] mem [DEPTH];

  always_ff @(posedge clk_in) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
    instruction <= mem[addr];
  end

  // Skip the cycle after a valid so the cpu can move its pointer first
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid <= 1'b0;
    end else begin
      valid <= ready && !valid;
    end
  end

endmodule

//--- cpu.sv
`timescale 1ns/1ps

module cpu #(
  parameter int PROGRAM_DEPTH = 64,
  parameter int DATA_DEPTH = 16,
  parameter int WEIGHT_DEPTH = 16,
  parameter int HEAP_DEPTH = 16,
  parameter logic [cpu_pkg::W_SIZE-1:0] LFSR_SEED = 16'hb26
) (
  input  logic                                 clk_in,
  input  logic                                 rst_in,
  output logic [$clog2(PROGRAM_DEPTH)-1:0]     instruction_addr,
  output logic                                 instruction_ready,
  input  logic [cpu_pkg::INSTR_SIZE-1:0]       instruction_in,
  input  logic                                 instruction_valid,
  output logic [$clog2(DATA_DEPTH)-1:0]        data_addr,
  output logic                                 data_read_en,
  input  cpu_pkg::xy_pair_t                    data_in,
  input  logic                                 data_finished,
  output logic [$clog2(WEIGHT_DEPTH)-1:0]      weight_addr,
  input  logic [cpu_pkg::W_SIZE-1:0]           weight_in,
  output logic [cpu_pkg::W_SIZE-1:0]           weight_out,
  output logic                                 weight_read_en,
  output logic                                 weight_write_en,
  input  logic                                 weight_finished,
  output logic [$clog2(HEAP_DEPTH)-1:0]        heap_addr,
  input  logic [cpu_pkg::X_SIZE-1:0]           heap_in,
  output logic [cpu_pkg::X_SIZE-1:0]           heap_out,
  output logic                                 heap_read_en,
  output logic                                 heap_write_en,
  input  logic                                 heap_finished,
  output logic [cpu_pkg::X_SIZE-1:0]           inference_out,
  output logic                                 inference_valid
);

  localparam int D_AW = $clog2(DATA_DEPTH);
  localparam int A_AW = $clog2(WEIGHT_DEPTH);
  localparam int H_AW = $clog2(HEAP_DEPTH);

  typedef enum logic [1:0] {
    st_idle,     // Waiting for an opcode
    st_operand,  // Waiting for the second word
    st_busy      // Waiting for a memory
  } state_e;

  state_e                         state;
  cpu_pkg::op_e                   op;
  cpu_pkg::op_e                   pend_op;
  logic [D_AW-1:0]                d_ptr;
  logic [A_AW-1:0]                a_ptr;
  logic [cpu_pkg::X_SIZE-1:0]     x_reg, y_reg;
  logic [cpu_pkg::W_SIZE-1:0]     w_reg, grad_reg;
  logic [cpu_pkg::TRIT_SIZE-1:0]  trit;
  logic                           consume;
  logic                           mem_done;
  logic [cpu_pkg::X_SIZE-1:0]     iw_y, biw_x;
  logic [cpu_pkg::W_SIZE-1:0]     biw_grad, sg_flip;

  interweave u_interweave (.x(x_reg), .w(w_reg), .trit(trit), .y(iw_y));

  binterweave u_binterweave (
    .y(y_reg), .w(w_reg), .trit(trit), .x(biw_x), .grad(biw_grad)
  );

  stoch_grad #(.SEED(LFSR_SEED)) u_stoch_grad (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .step(consume && op == cpu_pkg::stoch_grad), // One step per instruction
    .grad(grad_reg),
    .flip(sg_flip)
  );

  assign op = cpu_pkg::op_e'(instruction_in[4:0]);
  assign instruction_ready = (state != st_busy);   // Operand wait still fetches
  assign consume = (state == st_idle) && instruction_valid;
  assign mem_done = data_finished | weight_finished | heap_finished;
  assign data_addr = d_ptr;
  assign weight_addr = a_ptr;
  assign weight_out = w_reg;                        // Stable through the busy wait
  assign heap_out = x_reg;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= st_idle;
      pend_op <= cpu_pkg::set_i_0;
      instruction_addr <= '0;
      d_ptr <= '0;
      a_ptr <= '0;
      heap_addr <= '0;
      x_reg <= '0;
      y_reg <= '0;
      w_reg <= '0;
      grad_reg <= '0;
      trit <= '0;
      data_read_en <= 1'b0;
      weight_read_en <= 1'b0;
      weight_write_en <= 1'b0;
      heap_read_en <= 1'b0;
      heap_write_en <= 1'b0;
      inference_out <= '0;
      inference_valid <= 1'b0;
    end else begin
      data_read_en <= 1'b0;     // Strobes last one cycle
      weight_read_en <= 1'b0;
      weight_write_en <= 1'b0;
      heap_read_en <= 1'b0;
      heap_write_en <= 1'b0;
      inference_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (consume) begin
            pend_op <= op;
            instruction_addr <= (op == cpu_pkg::set_i_0) ? '0 : instruction_addr + 1'b1;
            case (op)
              cpu_pkg::set_trit_next, cpu_pkg::set_h_next: state <= st_operand;
              cpu_pkg::d_inc: d_ptr <= (d_ptr == D_AW'(DATA_DEPTH - 1)) ? '0 : d_ptr + 1'b1;
              cpu_pkg::d_dec: d_ptr <= (d_ptr == '0) ? D_AW'(DATA_DEPTH - 1) : d_ptr - 1'b1;
              cpu_pkg::a_inc: a_ptr <= (a_ptr == A_AW'(WEIGHT_DEPTH - 1)) ? '0 : a_ptr + 1'b1;
              cpu_pkg::a_dec: a_ptr <= (a_ptr == '0) ? A_AW'(WEIGHT_DEPTH - 1) : a_ptr - 1'b1;
              cpu_pkg::x_from_d0, cpu_pkg::y_from_d1, cpu_pkg::xy_from_d: begin
                data_read_en <= 1'b1;
                state <= st_busy;
              end
              cpu_pkg::w_from_a: begin
                weight_read_en <= 1'b1;
                state <= st_busy;
              end
              cpu_pkg::a_from_w: begin
                weight_write_en <= 1'b1;
                state <= st_busy;
              end
              cpu_pkg::x_from_h: begin
                heap_read_en <= 1'b1;
                state <= st_busy;
              end
              cpu_pkg::h_from_x: begin
                heap_write_en <= 1'b1;
                state <= st_busy;
              end
              cpu_pkg::inference_from_y: begin
                inference_out <= y_reg;
                inference_valid <= 1'b1;
              end
              cpu_pkg::swap_xy: begin
                x_reg <= y_reg;
                y_reg <= x_reg;
              end
              cpu_pkg::x_from_y: x_reg <= y_reg;
              cpu_pkg::y_from_x: y_reg <= x_reg;
              cpu_pkg::x_xor: x_reg <= x_reg ^ y_reg;
              cpu_pkg::y_xor: y_reg <= x_reg ^ y_reg;
              cpu_pkg::x_and: x_reg <= x_reg & y_reg;
              cpu_pkg::y_and: y_reg <= x_reg & y_reg;
              cpu_pkg::x_or: x_reg <= x_reg | y_reg;
              cpu_pkg::y_or: y_reg <= x_reg | y_reg;
              cpu_pkg::interweave: x_reg <= iw_y;
              cpu_pkg::backprop: begin
                y_reg <= biw_x;
                grad_reg <= biw_grad;
              end
              cpu_pkg::stoch_grad: w_reg <= w_reg ^ sg_flip;
              default: ;   // set_i_0 and unused codes only move the pointer
            endcase
          end
        end
        st_operand: begin
          if (instruction_valid) begin
            instruction_addr <= instruction_addr + 1'b1;
            if (pend_op == cpu_pkg::set_trit_next) begin
              trit <= instruction_in[cpu_pkg::TRIT_SIZE-1:0];
            end else begin
              heap_addr <= instruction_in[H_AW-1:0];
            end
            state <= st_idle;
          end
        end
        default: begin
          if (mem_done) begin
            case (pend_op)
              cpu_pkg::x_from_d0: x_reg <= data_in.x;
              cpu_pkg::y_from_d1: y_reg <= data_in.y;
              cpu_pkg::xy_from_d: begin
                x_reg <= data_in.x;
                y_reg <= data_in.y;
              end
              cpu_pkg::w_from_a: w_reg <= weight_in;
              cpu_pkg::x_from_h: x_reg <= heap_in;
              default: ;   // Writes have nothing to capture
            endcase
            state <= st_idle;
          end
        end
      endcase
    end
  end

endmodule

//--- neural_soc_top.sv
`timescale 1ns/1ps

module neural_soc_top #(
  parameter int PROGRAM_DEPTH = 64,
  parameter int DATA_DEPTH = 16,
  parameter int WEIGHT_DEPTH = 16,
  parameter int HEAP_DEPTH = 16,
  parameter int MEM_LATENCY = 2,
  parameter logic [cpu_pkg::W_SIZE-1:0] LFSR_SEED = 16'hb26
) (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       load_en,
  input  cpu_pkg::load_sel_e         load_sel,
  input  logic [15:0]                load_addr,
  input  logic [31:0]                load_data,
  output logic [cpu_pkg::X_SIZE-1:0] inference_out,
  output logic                       inference_valid
);

  localparam int P_AW = $clog2(PROGRAM_DEPTH);
  localparam int D_AW = $clog2(DATA_DEPTH);
  localparam int A_AW = $clog2(WEIGHT_DEPTH);
  localparam int H_AW = $clog2(HEAP_DEPTH);

  logic [P_AW-1:0]                 instruction_addr;
  logic                            instruction_ready, instruction_valid;
  logic [cpu_pkg::INSTR_SIZE-1:0]  instruction;
  logic [D_AW-1:0]                 data_addr;
  logic                            data_read_en, data_finished;
  cpu_pkg::xy_pair_t               data_rdata;
  logic [A_AW-1:0]                 weight_addr;
  logic [cpu_pkg::W_SIZE-1:0]      weight_rdata, weight_wdata;
  logic                            weight_read_en, weight_write_en, weight_finished;
  logic [H_AW-1:0]                 heap_addr;
  logic [cpu_pkg::X_SIZE-1:0]      heap_rdata, heap_wdata;
  logic                            heap_read_en, heap_write_en, heap_finished;
  logic                            load_program, load_dmem, load_wmem, load_hmem;

  // Steer the load port to one store
  assign load_program = load_en && (load_sel == cpu_pkg::sel_program);
  assign load_dmem    = load_en && (load_sel == cpu_pkg::sel_data);
  assign load_wmem    = load_en && (load_sel == cpu_pkg::sel_weight);
  assign load_hmem    = load_en && (load_sel == cpu_pkg::sel_heap);

  cpu #(
    .PROGRAM_DEPTH(PROGRAM_DEPTH), .DATA_DEPTH(DATA_DEPTH), .WEIGHT_DEPTH(WEIGHT_DEPTH),
    .HEAP_DEPTH(HEAP_DEPTH), .LFSR_SEED(LFSR_SEED)
  ) u_cpu (
    .clk_in(clk_in), .rst_in(rst_in),
    .instruction_addr(instruction_addr), .instruction_ready(instruction_ready),
    .instruction_in(instruction), .instruction_valid(instruction_valid),
    .data_addr(data_addr), .data_read_en(data_read_en),
    .data_in(data_rdata), .data_finished(data_finished),
    .weight_addr(weight_addr), .weight_in(weight_rdata), .weight_out(weight_wdata),
    .weight_read_en(weight_read_en), .weight_write_en(weight_write_en),
    .weight_finished(weight_finished),
    .heap_addr(heap_addr), .heap_in(heap_rdata), .heap_out(heap_wdata),
    .heap_read_en(heap_read_en), .heap_write_en(heap_write_en),
    .heap_finished(heap_finished),
    .inference_out(inference_out), .inference_valid(inference_valid)
  );

  program_rom #(.DEPTH(PROGRAM_DEPTH)) u_program_rom (
    .clk_in(clk_in), .rst_in(rst_in),
    .addr(instruction_addr), .ready(instruction_ready),
    .instruction(instruction), .valid(instruction_valid),
    .load_en(load_program), .load_addr(load_addr[P_AW-1:0]),
    .load_data(load_data[cpu_pkg::INSTR_SIZE-1:0])
  );

  // Data memory is read only for the cpu
  medium_mem #(
    .word_t(cpu_pkg::xy_pair_t), .DEPTH(DATA_DEPTH), .LATENCY(MEM_LATENCY)
  ) u_data_mem (
    .clk_in(clk_in), .rst_in(rst_in),
    .addr(data_addr), .read_en(data_read_en), .write_en(1'b0), .wdata('0),
    .rdata(data_rdata), .finished(data_finished),
    .load_en(load_dmem), .load_addr(load_addr[D_AW-1:0]),
    .load_data(cpu_pkg::xy_pair_t'(load_data))
  );

  medium_mem #(
    .word_t(logic [cpu_pkg::W_SIZE-1:0]), .DEPTH(WEIGHT_DEPTH), .LATENCY(MEM_LATENCY)
  ) u_weight_mem (
    .clk_in(clk_in), .rst_in(rst_in),
    .addr(weight_addr), .read_en(weight_read_en), .write_en(weight_write_en),
    .wdata(weight_wdata), .rdata(weight_rdata), .finished(weight_finished),
    .load_en(load_wmem), .load_addr(load_addr[A_AW-1:0]),
    .load_data(load_data[cpu_pkg::W_SIZE-1:0])
  );

  medium_mem #(
    .word_t(logic [cpu_pkg::X_SIZE-1:0]), .DEPTH(HEAP_DEPTH), .LATENCY(MEM_LATENCY)
  ) u_heap_mem (
    .clk_in(clk_in), .rst_in(rst_in),
    .addr(heap_addr), .read_en(heap_read_en), .write_en(heap_write_en),
    .wdata(heap_wdata), .rdata(heap_rdata), .finished(heap_finished),
    .load_en(load_hmem), .load_addr(load_addr[H_AW-1:0]),
    .load_data(load_data[cpu_pkg::X_SIZE-1:0])
  );

endmodule

//--- tb_neural_soc.sv
`timescale 1ns/1ps

module tb_neural_soc;

  localparam int P_DEPTH = 16;
  localparam int D_DEPTH = 4;
  localparam int W_DEPTH = 4;
  localparam int H_DEPTH = 8;
  localparam int LATENCY = 2;
  localparam int NUM_TESTS = 6;
  localparam logic [31:0] SEED = 32'hb26;
  localparam int LIMIT = NUM_TESTS * (P_DEPTH * 20 + 7 + P_DEPTH + D_DEPTH + W_DEPTH);

  // One row per test, operands sit in the word after their opcode
  localparam logic [4:0] PROG_TAB [NUM_TESTS][P_DEPTH] = '{
    '{cpu_pkg::xy_from_d, cpu_pkg::y_and, cpu_pkg::inference_from_y, cpu_pkg::d_dec,
      cpu_pkg::x_from_d0, cpu_pkg::x_or, cpu_pkg::y_xor, cpu_pkg::inference_from_y,
      cpu_pkg::d_inc, cpu_pkg::y_from_d1, cpu_pkg::x_and, cpu_pkg::x_xor,
      cpu_pkg::swap_xy, cpu_pkg::inference_from_y, cpu_pkg::y_or, cpu_pkg::inference_from_y},
    '{cpu_pkg::xy_from_d, cpu_pkg::set_trit_next, 5'd5, cpu_pkg::w_from_a,
      cpu_pkg::interweave, cpu_pkg::y_from_x, cpu_pkg::backprop, cpu_pkg::inference_from_y,
      cpu_pkg::d_inc, cpu_pkg::x_from_d0, cpu_pkg::set_trit_next, 5'd11,
      cpu_pkg::interweave, cpu_pkg::y_from_x, cpu_pkg::backprop, cpu_pkg::inference_from_y},
    '{cpu_pkg::w_from_a, cpu_pkg::a_dec, cpu_pkg::a_from_w, cpu_pkg::a_inc,
      cpu_pkg::a_inc, cpu_pkg::w_from_a, cpu_pkg::a_dec, cpu_pkg::a_dec,
      cpu_pkg::w_from_a, cpu_pkg::interweave, cpu_pkg::y_from_x, cpu_pkg::inference_from_y,
      cpu_pkg::xy_from_d, cpu_pkg::interweave, cpu_pkg::y_from_x, cpu_pkg::inference_from_y},
    '{cpu_pkg::xy_from_d, cpu_pkg::set_h_next, 5'd6, cpu_pkg::h_from_x,
      cpu_pkg::x_xor, cpu_pkg::x_or, cpu_pkg::y_from_x, cpu_pkg::inference_from_y,
      cpu_pkg::x_from_h, cpu_pkg::y_from_x, cpu_pkg::inference_from_y, cpu_pkg::x_from_y,
      cpu_pkg::set_i_0, cpu_pkg::set_i_0, cpu_pkg::set_i_0, cpu_pkg::set_i_0},
    '{cpu_pkg::xy_from_d, cpu_pkg::w_from_a, cpu_pkg::backprop, cpu_pkg::stoch_grad,
      cpu_pkg::interweave, cpu_pkg::y_from_x, cpu_pkg::inference_from_y, cpu_pkg::backprop,
      cpu_pkg::stoch_grad, cpu_pkg::interweave, cpu_pkg::y_from_x, cpu_pkg::inference_from_y,
      cpu_pkg::stoch_grad, cpu_pkg::interweave, cpu_pkg::y_from_x, cpu_pkg::inference_from_y},
    '{cpu_pkg::d_inc, cpu_pkg::xy_from_d, cpu_pkg::y_xor, cpu_pkg::x_from_y,
      cpu_pkg::inference_from_y, cpu_pkg::set_i_0, cpu_pkg::set_i_0, cpu_pkg::set_i_0,
      cpu_pkg::set_i_0, cpu_pkg::set_i_0, cpu_pkg::set_i_0, cpu_pkg::set_i_0,
      cpu_pkg::set_i_0, cpu_pkg::set_i_0, cpu_pkg::set_i_0, cpu_pkg::set_i_0}
  };
  localparam int INFER_CNT [NUM_TESTS] = '{4, 2, 2, 2, 3, 8}; // Loop row runs two passes

  logic                 clk_in;
  logic                 rst_in;
  logic                 load_en;
  cpu_pkg::load_sel_e   load_sel;
  logic [15:0]          load_addr;
  logic [31:0]          load_data;
  logic [15:0]          inference_out;
  logic                 inference_valid;
  logic [15:0]          rand_state;
  cpu_pkg::xy_pair_t    data_img [D_DEPTH];
  logic [15:0]          weight_img [W_DEPTH];
  logic [15:0]          expected [$];
  int                   checks;
  int                   errors;

  neural_soc_top #(
    .PROGRAM_DEPTH(P_DEPTH), .DATA_DEPTH(D_DEPTH), .WEIGHT_DEPTH(W_DEPTH),
    .HEAP_DEPTH(H_DEPTH), .MEM_LATENCY(LATENCY), .LFSR_SEED(SEED[15:0])
  ) DUT (
    .clk_in(clk_in), .rst_in(rst_in), .load_en(load_en), .load_sel(load_sel),
    .load_addr(load_addr), .load_data(load_data),
    .inference_out(inference_out), .inference_valid(inference_valid)
  );

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000); // Galois form, taps 0xB400
  endfunction

  function automatic logic [15:0] rand_word();
    logic [15:0] r;
    r = '0;
    for (int b = 0; b < 16; b++) begin
      rand_state = lfsr_step(rand_state);
      r = {r[14:0], rand_state[0]};      // One step per bit taken
    end
    return r;
  endfunction

  // Output bit i takes x bit (i + t) mod 16
  function automatic logic [15:0] rotate_mix(input logic [15:0] x, w, input logic [3:0] t);
    logic [31:0] both;
    both = {x, x} >> t;
    return both[15:0] ^ w;
  endfunction

  // Output bit j takes (y ^ w) bit (j - t) mod 16
  function automatic logic [15:0] unmix_rotate(input logic [15:0] y, w, input logic [3:0] t);
    logic [31:0] both;
    both = {y ^ w, y ^ w} << t;
    return both[31:16];
  endfunction

  task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Instruction level model, stops once the row's inferences are produced
  task automatic predict_inferences(input int t);
    logic [15:0] x = '0, y = '0, w = '0, grad = '0;
    logic [15:0] lfsr = SEED[15:0];
    logic [15:0] wmem [W_DEPTH];
    logic [15:0] hmem [H_DEPTH];
    logic [3:0]  trit = '0;
    int          i = 0, d = 0, a = 0, h = 0, steps = 0;
    wmem = weight_img;
    hmem = '{default: '0};
    expected.delete();
    while (expected.size() < INFER_CNT[t] && steps < 400) begin
      steps++;
      case (cpu_pkg::op_e'(PROG_TAB[t][i]))
        cpu_pkg::set_i_0: i = -1;                   // Incremented to 0 below
        cpu_pkg::set_trit_next: begin
          i = (i + 1) % P_DEPTH;
          trit = PROG_TAB[t][i][3:0];
        end
        cpu_pkg::set_h_next: begin
          i = (i + 1) % P_DEPTH;
          h = int'(PROG_TAB[t][i]) % H_DEPTH;
        end
        cpu_pkg::d_inc: d = (d + 1) % D_DEPTH;
        cpu_pkg::d_dec: d = (d + D_DEPTH - 1) % D_DEPTH;
        cpu_pkg::a_inc: a = (a + 1) % W_DEPTH;
        cpu_pkg::a_dec: a = (a + W_DEPTH - 1) % W_DEPTH;
        cpu_pkg::x_from_d0: x = data_img[d].x;
        cpu_pkg::y_from_d1: y = data_img[d].y;
        cpu_pkg::xy_from_d: {x, y} = {data_img[d].x, data_img[d].y};
        cpu_pkg::inference_from_y: expected.push_back(y);
        cpu_pkg::w_from_a: w = wmem[a];
        cpu_pkg::a_from_w: wmem[a] = w;
        cpu_pkg::x_from_h: x = hmem[h];
        cpu_pkg::h_from_x: hmem[h] = x;
        cpu_pkg::swap_xy: {x, y} = {y, x};
        cpu_pkg::x_from_y: x = y;
        cpu_pkg::y_from_x: y = x;
        cpu_pkg::x_xor: x = x ^ y;
        cpu_pkg::y_xor: y = x ^ y;
        cpu_pkg::x_and: x = x & y;
        cpu_pkg::y_and: y = x & y;
        cpu_pkg::x_or: x = x | y;
        cpu_pkg::y_or: y = x | y;
        cpu_pkg::interweave: x = rotate_mix(x, w, trit);
        cpu_pkg::backprop: begin
          grad = y ^ w;                             // Taken from Y before it changes
          y = unmix_rotate(y, w, trit);
        end
        cpu_pkg::stoch_grad: begin
          w = w ^ (grad & lfsr);
          lfsr = lfsr_step(lfsr);
        end
        default: ;
      endcase
      i = (i + 1) % P_DEPTH;
    end
  endtask

  task automatic load_word(input cpu_pkg::load_sel_e sel, input int addr, input logic [31:0] data);
    @(posedge clk_in);
    load_en <= 1'b1;
    load_sel <= sel;
    load_addr <= 16'(addr);
    load_data <= data;
  endtask

  task automatic run_test(input int t);
    int errors_before;
    errors_before = errors;
    for (int k = 0; k < D_DEPTH; k++) begin
      data_img[k].x = rand_word();
      data_img[k].y = rand_word();
    end
    for (int k = 0; k < W_DEPTH; k++) weight_img[k] = rand_word();
    predict_inferences(t);
    @(posedge clk_in);
    rst_in <= 1'b1;
    repeat (5) @(posedge clk_in);
    for (int k = 0; k < P_DEPTH; k++) load_word(cpu_pkg::sel_program, k, {27'd0, PROG_TAB[t][k]});
    for (int k = 0; k < D_DEPTH; k++) load_word(cpu_pkg::sel_data, k, data_img[k]);
    for (int k = 0; k < W_DEPTH; k++) load_word(cpu_pkg::sel_weight, k, {16'h0000, weight_img[k]});
    @(posedge clk_in);
    load_en <= 1'b0;
    rst_in <= 1'b0;
    for (int k = 0; k < expected.size(); k++) begin
      @(negedge clk_in);
      while (!inference_valid) @(negedge clk_in);
      check_value("inference_out", inference_out, expected[k]);
      @(negedge clk_in);
      check_value("inference_valid", 16'(inference_valid), 16'h0000); // Single cycle pulse
    end
    $display("Test %0d done: %0d inferences, %0d errors", t + 1, expected.size(),
             errors - errors_before);
  endtask

  initial begin
    rst_in = 1'b1;
    load_en = 1'b0;
    load_sel = cpu_pkg::sel_program;
    load_addr = '0;
    load_data = '0;
    rand_state = SEED[15:0];
    checks = 0;
    errors = 0;
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT) @(posedge clk_in);
    $display("Run stopped after %0d cycles without finishing the tests", LIMIT);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- src.f
cpu_pkg.sv
interweave.sv
binterweave.sv
stoch_grad.sv
medium_mem.sv
program_rom.sv
cpu.sv
neural_soc_top.sv
tb_neural_soc.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_neural_soc -f src.f -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
